// File: logic/priv_isa_pkg.sv
/* architectural types for the M/S trap unit. irq_vec_t bit 5 is MEI down to bit 0 STI,
   which is also the fixed priority. irq_enable and mideleg use this bit order and not the
   cause numbers. mstatus keeps only MIE, SIE, MPIE, SPIE, MPP and SPP. */
package priv_isa_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11  // 2'b10 is reserved and never held.
    } priv_level_e;

    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  cause_code_t;
    typedef logic [5:0]  irq_vec_t;

    // bit index of each line in irq_vec_t, highest priority first.
    localparam int IRQ_MEI = 5;
    localparam int IRQ_MSI = 4;
    localparam int IRQ_MTI = 3;
    localparam int IRQ_SEI = 2;
    localparam int IRQ_SSI = 1;
    localparam int IRQ_STI = 0;

    localparam cause_code_t CAUSE_MEI = 5'd11;
    localparam cause_code_t CAUSE_MSI = 5'd3;
    localparam cause_code_t CAUSE_MTI = 5'd7;
    localparam cause_code_t CAUSE_SEI = 5'd9;
    localparam cause_code_t CAUSE_SSI = 5'd1;
    localparam cause_code_t CAUSE_STI = 5'd5;

    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_IRQ_ENABLE = 12'h304; // sits where mie would be.
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_STVEC      = 12'h105;
    localparam csr_addr_t CSR_SEPC       = 12'h141;
    localparam csr_addr_t CSR_SCAUSE     = 12'h142;

    typedef struct packed {
        logic [29:0] base; // trap handler address bits 31:2.
        logic [1:0]  mode;
    } tvec_t;

    localparam logic [1:0] TVEC_DIRECT   = 2'b00;
    localparam logic [1:0] TVEC_VECTORED = 2'b01;

    // mstatus field positions, as in the privileged spec.
    localparam int MSTATUS_SIE    = 1;
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_SPIE   = 5;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_SPP    = 8;
    localparam int MSTATUS_MPP_LO = 11;

    localparam word_t EPC_MASK     = 32'hFFFF_FFFC; // pc is word aligned.
    localparam word_t TVEC_MASK    = 32'hFFFF_FFFD; // mode bit 1 is hardwired to zero.
    localparam word_t MSTATUS_MASK = 32'h0000_19AA; // MPP, SPP, MPIE, SPIE, MIE, SIE.

endpackage

// File: logic/priv_bus_pkg.sv
/* structs that cross the unit boundary and link its three blocks.
   the APB side is a 12-bit CSR-numbered port with no wait states.
   csr_view_t is the registered CSR state that the trap logic reads. */
package priv_bus_pkg;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        priv_isa_pkg::csr_addr_t  paddr;  // CSR number, not a byte address.
        priv_isa_pkg::word_t      pwdata;
    } apb_req_t;

    typedef struct packed {
        priv_isa_pkg::word_t prdata;
        logic                pready;
        logic                pslverr;
    } apb_rsp_t;

    // return request from the pipeline, held for exactly one cycle.
    typedef struct packed {
        logic                mret;
        logic                sret;
        priv_isa_pkg::word_t epc;    // where the pipeline resumes, saved on a trap.
    } ret_req_t;

    typedef struct packed {
        logic                      take_intr;
        logic                      to_s;      // trap lands in S mode when set.
        priv_isa_pkg::cause_code_t cause;
        logic                      do_mret;
        logic                      do_sret;
    } trap_dec_t;

    typedef struct packed {
        logic                      mie;
        logic                      sie;
        logic                      mpie;
        logic                      spie;
        priv_isa_pkg::priv_level_e mpp;
        logic                      spp;   // one when the trap came from S.
    } mstatus_view_t;

    typedef struct packed {
        priv_isa_pkg::tvec_t    mtvec;
        priv_isa_pkg::tvec_t    stvec;
        priv_isa_pkg::word_t    mepc;
        priv_isa_pkg::word_t    sepc;
        mstatus_view_t          mstatus;
        priv_isa_pkg::irq_vec_t mideleg;    // a set bit hands that line to S mode.
        priv_isa_pkg::irq_vec_t irq_enable;
    } csr_view_t;

endpackage

// File: logic/priv_trap_ctrl.sv
/* picks one interrupt per cycle from the six pins and decides M or S delegation.
   an enabled interrupt always beats mret, and mret beats sret.
   the privilege level changes at the edge that ends the event cycle. */
`timescale 1ns/10ps

module priv_trap_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  priv_isa_pkg::irq_vec_t    irq,
    input  priv_bus_pkg::ret_req_t    ret,
    input  priv_bus_pkg::csr_view_t   csr,
    output priv_bus_pkg::trap_dec_t   dec,
    output priv_isa_pkg::priv_level_e priv_level
);

    priv_isa_pkg::irq_vec_t    pending;  // pins masked by irq_enable.
    priv_isa_pkg::irq_vec_t    take;     // pending lines that may trap right now.
    logic                      m_global; // M-bound lines are open.
    logic                      s_global; // S-bound lines are open.
    priv_isa_pkg::priv_level_e priv_next;

    assign pending = irq & csr.irq_enable;

    // a lower level always admits M-bound lines, and in M the MIE bit decides.
    assign m_global = (priv_level != priv_isa_pkg::PRIV_M) | csr.mstatus.mie;

    // S-bound lines never interrupt M mode.
    assign s_global = (priv_level == priv_isa_pkg::PRIV_U)
                    | ((priv_level == priv_isa_pkg::PRIV_S) & csr.mstatus.sie);

    assign take = pending & ((~csr.mideleg & {6{m_global}}) | (csr.mideleg & {6{s_global}}));

    always_comb begin
        dec = '0;
        // fixed priority, MEI first and STI last.
        if (take[priv_isa_pkg::IRQ_MEI]) begin
            dec.cause = priv_isa_pkg::CAUSE_MEI;
            dec.to_s  = csr.mideleg[priv_isa_pkg::IRQ_MEI];
        end else if (take[priv_isa_pkg::IRQ_MSI]) begin
            dec.cause = priv_isa_pkg::CAUSE_MSI;
            dec.to_s  = csr.mideleg[priv_isa_pkg::IRQ_MSI];
        end else if (take[priv_isa_pkg::IRQ_MTI]) begin
            dec.cause = priv_isa_pkg::CAUSE_MTI;
            dec.to_s  = csr.mideleg[priv_isa_pkg::IRQ_MTI];
        end else if (take[priv_isa_pkg::IRQ_SEI]) begin
            dec.cause = priv_isa_pkg::CAUSE_SEI;
            dec.to_s  = csr.mideleg[priv_isa_pkg::IRQ_SEI];
        end else if (take[priv_isa_pkg::IRQ_SSI]) begin
            dec.cause = priv_isa_pkg::CAUSE_SSI;
            dec.to_s  = csr.mideleg[priv_isa_pkg::IRQ_SSI];
        end else if (take[priv_isa_pkg::IRQ_STI]) begin
            dec.cause = priv_isa_pkg::CAUSE_STI;
            dec.to_s  = csr.mideleg[priv_isa_pkg::IRQ_STI];
        end
        dec.take_intr = |take;
        // a taken interrupt swallows a return in the same cycle.
        dec.do_mret   = ret.mret & ~dec.take_intr;
        dec.do_sret   = ret.sret & ~ret.mret & ~dec.take_intr;
    end

    always_comb begin
        priv_next = priv_level; // hold unless an event fires.
        if (dec.take_intr) begin
            priv_next = dec.to_s ? priv_isa_pkg::PRIV_S : priv_isa_pkg::PRIV_M;
        end else if (dec.do_mret) begin
            priv_next = csr.mstatus.mpp; // MPP is kept legal by the CSR file.
        end else if (dec.do_sret) begin
            priv_next = csr.mstatus.spp ? priv_isa_pkg::PRIV_S : priv_isa_pkg::PRIV_U;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            priv_level <= priv_isa_pkg::PRIV_M; // the hart boots in machine mode.
        end else begin
            priv_level <= priv_next;
        end
    end

    // The pipeline retires at most one return instruction per cycle.
    assert property (@(posedge clk) disable iff (!rst_n) !(ret.mret && ret.sret))
        else $error("mret and sret requested in the same cycle.");

    // the level only ever comes from the enum or from MPP written over APB.
    assert property (@(posedge clk) disable iff (!rst_n)
        priv_level inside {priv_isa_pkg::PRIV_U, priv_isa_pkg::PRIV_S, priv_isa_pkg::PRIV_M})
        else $error("privilege register holds a reserved encoding.");

endmodule

// File: logic/priv_csr_file.sv
/* trap CSRs behind a zero-wait APB port, keyed by CSR number.
   mcause and scause are plain words. a written MPP of 2'b10 is stored as U.
   in a cycle with a trap or return, that event replaces any APB write to the CSRs it touches. */
`timescale 1ns/10ps

module priv_csr_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  priv_bus_pkg::apb_req_t    apb_req,
    input  priv_bus_pkg::trap_dec_t   dec,
    input  priv_isa_pkg::word_t       epc,
    input  priv_isa_pkg::priv_level_e priv_level,
    output priv_bus_pkg::apb_rsp_t    apb_rsp,
    output priv_bus_pkg::csr_view_t   csr
);

    priv_bus_pkg::csr_view_t csr_d;
    priv_isa_pkg::word_t     mcause_q;
    priv_isa_pkg::word_t     mcause_d;
    priv_isa_pkg::word_t     scause_q;
    priv_isa_pkg::word_t     scause_d;
    priv_isa_pkg::word_t     rdata;
    logic                    hit;       // paddr names a CSR in this file.
    logic                    access;    // APB access phase.
    logic                    apb_wr;

    // spread the mstatus fields back to their architectural bits.
    function automatic priv_isa_pkg::word_t mstatus_pack(input priv_bus_pkg::mstatus_view_t s);
        priv_isa_pkg::word_t w;
        w = '0;
        w[priv_isa_pkg::MSTATUS_SIE]          = s.sie;
        w[priv_isa_pkg::MSTATUS_MIE]          = s.mie;
        w[priv_isa_pkg::MSTATUS_SPIE]         = s.spie;
        w[priv_isa_pkg::MSTATUS_MPIE]         = s.mpie;
        w[priv_isa_pkg::MSTATUS_SPP]          = s.spp;
        w[priv_isa_pkg::MSTATUS_MPP_LO +: 2]  = s.mpp;
        return w;
    endfunction

    function automatic priv_bus_pkg::mstatus_view_t mstatus_unpack(input priv_isa_pkg::word_t d);
        priv_isa_pkg::word_t           w;
        logic [1:0]                    mpp_bits;
        priv_bus_pkg::mstatus_view_t   s;
        w        = d & priv_isa_pkg::MSTATUS_MASK;
        mpp_bits = w[priv_isa_pkg::MSTATUS_MPP_LO +: 2];
        s.sie    = w[priv_isa_pkg::MSTATUS_SIE];
        s.mie    = w[priv_isa_pkg::MSTATUS_MIE];
        s.spie   = w[priv_isa_pkg::MSTATUS_SPIE];
        s.mpie   = w[priv_isa_pkg::MSTATUS_MPIE];
        s.spp    = w[priv_isa_pkg::MSTATUS_SPP];
        // the reserved level falls back to U so that mret stays legal.
        s.mpp    = (mpp_bits == 2'b10) ? priv_isa_pkg::PRIV_U
                                       : priv_isa_pkg::priv_level_e'(mpp_bits);
        return s;
    endfunction

    assign access = apb_req.psel & apb_req.penable;
    assign apb_wr = access & apb_req.pwrite;

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (apb_req.paddr)
            priv_isa_pkg::CSR_MSTATUS:    rdata = mstatus_pack(csr.mstatus);
            priv_isa_pkg::CSR_MIDELEG:    rdata = priv_isa_pkg::word_t'(csr.mideleg);
            priv_isa_pkg::CSR_IRQ_ENABLE: rdata = priv_isa_pkg::word_t'(csr.irq_enable);
            priv_isa_pkg::CSR_MTVEC:      rdata = csr.mtvec;
            priv_isa_pkg::CSR_MEPC:       rdata = csr.mepc;
            priv_isa_pkg::CSR_MCAUSE:     rdata = mcause_q;
            priv_isa_pkg::CSR_STVEC:      rdata = csr.stvec;
            priv_isa_pkg::CSR_SEPC:       rdata = csr.sepc;
            priv_isa_pkg::CSR_SCAUSE:     rdata = scause_q;
            default:                      hit   = 1'b0;
        endcase
    end

    // the response is only live during the access phase.
    assign apb_rsp.prdata  = access ? rdata : '0;
    assign apb_rsp.pready  = access;
    assign apb_rsp.pslverr = access & ~hit;

    always_comb begin
        csr_d    = csr;
        mcause_d = mcause_q;
        scause_d = scause_q;
        if (apb_wr) begin
            case (apb_req.paddr)
                priv_isa_pkg::CSR_MSTATUS:    csr_d.mstatus    = mstatus_unpack(apb_req.pwdata);
                priv_isa_pkg::CSR_MIDELEG:    csr_d.mideleg    = apb_req.pwdata[5:0];
                priv_isa_pkg::CSR_IRQ_ENABLE: csr_d.irq_enable = apb_req.pwdata[5:0];
                priv_isa_pkg::CSR_MTVEC:      csr_d.mtvec = apb_req.pwdata & priv_isa_pkg::TVEC_MASK;
                priv_isa_pkg::CSR_MEPC:       csr_d.mepc  = apb_req.pwdata & priv_isa_pkg::EPC_MASK;
                priv_isa_pkg::CSR_MCAUSE:     mcause_d    = apb_req.pwdata;
                priv_isa_pkg::CSR_STVEC:      csr_d.stvec = apb_req.pwdata & priv_isa_pkg::TVEC_MASK;
                priv_isa_pkg::CSR_SEPC:       csr_d.sepc  = apb_req.pwdata & priv_isa_pkg::EPC_MASK;
                priv_isa_pkg::CSR_SCAUSE:     scause_d    = apb_req.pwdata;
                default: ;
            endcase
        end
        // events restart mstatus from the registered value, so a same-cycle write is lost.
        if (dec.take_intr && !dec.to_s) begin
            csr_d.mepc         = epc & priv_isa_pkg::EPC_MASK;
            mcause_d           = {1'b1, 26'd0, dec.cause}; // interrupt bit plus code.
            csr_d.mstatus      = csr.mstatus;
            csr_d.mstatus.mpie = csr.mstatus.mie;
            csr_d.mstatus.mie  = 1'b0;
            csr_d.mstatus.mpp  = priv_level;
        end else if (dec.take_intr) begin
            csr_d.sepc         = epc & priv_isa_pkg::EPC_MASK;
            scause_d           = {1'b1, 26'd0, dec.cause};
            csr_d.mstatus      = csr.mstatus;
            csr_d.mstatus.spie = csr.mstatus.sie;
            csr_d.mstatus.sie  = 1'b0;
            csr_d.mstatus.spp  = (priv_level == priv_isa_pkg::PRIV_S); // S traps come from U or S.
        end else if (dec.do_mret) begin
            csr_d.mstatus      = csr.mstatus;
            csr_d.mstatus.mie  = csr.mstatus.mpie;
            csr_d.mstatus.mpie = 1'b1;
            csr_d.mstatus.mpp  = priv_isa_pkg::PRIV_U;
        end else if (dec.do_sret) begin
            csr_d.mstatus      = csr.mstatus;
            csr_d.mstatus.sie  = csr.mstatus.spie;
            csr_d.mstatus.spie = 1'b1;
            csr_d.mstatus.spp  = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr      <= '0;
            mcause_q <= '0;
            scause_q <= '0;
        end else begin
            csr      <= csr_d;
            mcause_q <= mcause_d;
            scause_q <= scause_d;
        end
    end

    // the slave only answers an access phase that followed a setup phase.
    assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable
                            && $past(apb_req.psel && !apb_req.penable)))
        else $error("APB access phase without a setup phase.");

endmodule

// File: logic/priv_pipe_control.sv
/* turns the trap decision into a pipeline redirect, with no register stage.
   every taken event is an interrupt, so vectored mode always offsets by four times the cause.
   the pipeline must take insert_pc in the cycle it is high. */
`timescale 1ns/10ps

module priv_pipe_control (
    input  priv_bus_pkg::trap_dec_t dec,
    input  priv_bus_pkg::csr_view_t csr,
    output logic                    insert_pc,
    output priv_isa_pkg::word_t     priv_pc
);

    priv_isa_pkg::tvec_t vec;     // tvec of the mode the trap lands in.
    priv_isa_pkg::word_t vec_pc;
    priv_isa_pkg::word_t offset;  // vectored entry offset.

    // any interrupt or return redirects fetch.
    assign insert_pc = dec.take_intr | dec.do_mret | dec.do_sret;

    assign vec    = dec.to_s ? csr.stvec : csr.mtvec;
    assign offset = {25'd0, dec.cause, 2'b00}; // four bytes per cause slot.

    always_comb begin
        vec_pc = {vec.base, 2'b00}; // direct mode lands on the base.
        if (vec.mode == priv_isa_pkg::TVEC_VECTORED) begin
            vec_pc = vec_pc + offset;
        end
    end

    always_comb begin
        priv_pc = '0; // no redirect, nothing to point at.
        if (dec.take_intr) begin
            priv_pc = vec_pc;
        end else if (dec.do_mret) begin
            priv_pc = csr.mepc; // back to the interrupted code.
        end else if (dec.do_sret) begin
            priv_pc = csr.sepc;
        end
    end

endmodule

// File: logic/priv_unit.sv
/* trap and return unit for M and S mode.
   redirects are combinational in the event cycle and CSRs update at its closing edge.
   mret and sret must be held for exactly one cycle, and there is no back-pressure. */
`timescale 1ns/10ps

module priv_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  priv_bus_pkg::apb_req_t    apb_req,
    input  priv_isa_pkg::irq_vec_t    irq,
    input  priv_bus_pkg::ret_req_t    ret,
    output priv_bus_pkg::apb_rsp_t    apb_rsp,
    output logic                      insert_pc,
    output priv_isa_pkg::word_t       priv_pc,
    output priv_isa_pkg::priv_level_e priv_level
);

    priv_bus_pkg::csr_view_t csr;  // registered CSR state.
    priv_bus_pkg::trap_dec_t dec;  // this cycle's event.

    priv_trap_ctrl trap_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .irq        (irq),
        .ret        (ret),
        .csr        (csr),
        .dec        (dec),
        .priv_level (priv_level)
    );

    // the return epc doubles as the saved pc when an interrupt wins the cycle.
    priv_csr_file csr_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .dec        (dec),
        .epc        (ret.epc),
        .priv_level (priv_level),
        .apb_rsp    (apb_rsp),
        .csr        (csr)
    );

    priv_pipe_control pipe_control (
        .dec       (dec),
        .csr       (csr),
        .insert_pc (insert_pc),
        .priv_pc   (priv_pc)
    );

endmodule

// File: dv/priv_unit_tb.sv
/* random testbench for the trap unit, checked against a CSR and privilege model.
   inputs move 2 ns after the rising edge and outputs are sampled at the falling edge.
   irq and ret stay low outside event cycles, so APB traffic never meets a trap. */
`timescale 1ns/10ps

module priv_unit_tb;

    localparam int APB_TIMEOUT  = 16;        // cycles allowed for pready.
    localparam int RUN_LIMIT_NS = 1_000_000;
    localparam priv_isa_pkg::csr_addr_t CSR_LIST [9] = '{
        priv_isa_pkg::CSR_MSTATUS, priv_isa_pkg::CSR_MIDELEG, priv_isa_pkg::CSR_IRQ_ENABLE,
        priv_isa_pkg::CSR_MTVEC, priv_isa_pkg::CSR_MEPC, priv_isa_pkg::CSR_MCAUSE,
        priv_isa_pkg::CSR_STVEC, priv_isa_pkg::CSR_SEPC, priv_isa_pkg::CSR_SCAUSE};

    logic                      clk;
    logic                      rst_n;
    priv_bus_pkg::apb_req_t    apb_req;
    priv_isa_pkg::irq_vec_t    irq;
    priv_bus_pkg::ret_req_t    ret;
    priv_bus_pkg::apb_rsp_t    apb_rsp;
    logic                      insert_pc;
    priv_isa_pkg::word_t       priv_pc;
    priv_isa_pkg::priv_level_e priv_level;

    logic [31:0] lfsr_state;
    int          errors;
    int          timeouts;

    // model of the CSRs and the privilege level, U = 0, S = 1, M = 3.
    logic [31:0] m_mtvec;
    logic [31:0] m_stvec;
    logic [31:0] m_mepc;
    logic [31:0] m_sepc;
    logic [31:0] m_mcause;
    logic [31:0] m_scause;
    logic [5:0]  m_mideleg;
    logic [5:0]  m_irq_en;
    logic        m_mie;
    logic        m_sie;
    logic        m_mpie;
    logic        m_spie;
    logic        m_spp;
    logic [1:0]  m_mpp;
    logic [1:0]  m_priv;

    priv_unit uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .irq        (irq),
        .ret        (ret),
        .apb_rsp    (apb_rsp),
        .insert_pc  (insert_pc),
        .priv_pc    (priv_pc),
        .priv_level (priv_level)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(RUN_LIMIT_NS);
        $display("the run did not finish within its time limit.");
        $display("Simulation FAILED");
        $finish;
    end

    // right-shift Galois LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit taken.
            v[b] = lfsr_state[0];
        end
        return v;
    endfunction

    function automatic logic [4:0] cause_for_line(input int line);
        case (line)
            5:       return 5'd11; // MEI.
            4:       return 5'd3;  // MSI.
            3:       return 5'd7;  // MTI.
            2:       return 5'd9;  // SEI.
            1:       return 5'd1;  // SSI.
            default: return 5'd5;  // STI.
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            12'h300: return {19'd0, m_mpp, 2'b00, m_spp, m_mpie, 1'b0, m_spie, 1'b0,
                             m_mie, 1'b0, m_sie, 1'b0};
            12'h303: return {26'd0, m_mideleg};
            12'h304: return {26'd0, m_irq_en};
            12'h305: return m_mtvec;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h105: return m_stvec;
            12'h141: return m_sepc;
            12'h142: return m_scause;
            default: return 32'd0;
        endcase
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [31:0] d);
        case (addr)
            12'h300: begin
                m_sie  = d[1];
                m_mie  = d[3];
                m_spie = d[5];
                m_mpie = d[7];
                m_spp  = d[8];
                m_mpp  = (d[12:11] == 2'b10) ? 2'b00 : d[12:11]; // reserved level reads as U.
            end
            12'h303: m_mideleg = d[5:0];
            12'h304: m_irq_en  = d[5:0];
            12'h305: m_mtvec   = d & 32'hFFFF_FFFD;
            12'h341: m_mepc    = d & 32'hFFFF_FFFC;
            12'h342: m_mcause  = d;
            12'h105: m_stvec   = d & 32'hFFFF_FFFD;
            12'h141: m_sepc    = d & 32'hFFFF_FFFC;
            12'h142: m_scause  = d;
            default: ;
        endcase
    endtask

    // predicts the redirect of one event cycle, then moves the model past it.
    task automatic model_event(input logic [5:0] lines, input logic mret, input logic sret,
                               input logic [31:0] epc, output logic ins, output logic [31:0] pc);
        logic        found;
        logic        allowed;
        logic        to_s;
        logic [4:0]  cause;
        logic [31:0] vec;
        found = 1'b0;
        to_s  = 1'b0;
        cause = 5'd0;
        for (int i = 5; i >= 0; i--) begin
            if (m_mideleg[i]) allowed = (m_priv == 2'b00) || (m_priv == 2'b01 && m_sie);
            else allowed = (m_priv != 2'b11) || m_mie;
            if (!found && lines[i] && m_irq_en[i] && allowed) begin
                found = 1'b1;
                to_s  = m_mideleg[i];
                cause = cause_for_line(i);
            end
        end
        ins = found || mret || sret;
        pc  = 32'd0;
        if (found) begin
            vec = to_s ? m_stvec : m_mtvec;
            pc  = {vec[31:2], 2'b00};
            if (vec[1:0] == 2'b01) pc = pc + {25'd0, cause, 2'b00}; // vectored entry.
            if (to_s) begin
                m_sepc   = epc & 32'hFFFF_FFFC;
                m_scause = {1'b1, 26'd0, cause};
                m_spie   = m_sie;
                m_sie    = 1'b0;
                m_spp    = (m_priv == 2'b01);
                m_priv   = 2'b01;
            end else begin
                m_mepc   = epc & 32'hFFFF_FFFC;
                m_mcause = {1'b1, 26'd0, cause};
                m_mpie   = m_mie;
                m_mie    = 1'b0;
                m_mpp    = m_priv;
                m_priv   = 2'b11;
            end
        end else if (mret) begin
            pc     = m_mepc;
            m_mie  = m_mpie;
            m_mpie = 1'b1;
            m_priv = m_mpp;
            m_mpp  = 2'b00;
        end else if (sret) begin
            pc     = m_sepc;
            m_sie  = m_spie;
            m_spie = 1'b1;
            m_priv = m_spp ? 2'b01 : 2'b00;
            m_spp  = 1'b0;
        end
    endtask

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h.", $time, what, actual, expected);
        end
    endtask

    // one APB transfer runs a setup phase and then an access phase until pready.
    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!apb_rsp.pready && waited < APB_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!apb_rsp.pready) begin
            timeouts++;
            $display("APB access to CSR %h saw no pready within %0d cycles.", addr, APB_TIMEOUT);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk); // a write lands on this edge.
        #2;
        apb_req = '0;
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        model_write(addr, data);
        compare(32'(err), 32'd0, $sformatf("pslverr on write to CSR %h", addr));
    endtask

    task automatic csr_read_check(input logic [11:0] addr);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rd, err);
        compare(rd, model_read(addr), $sformatf("read of CSR %h", addr));
        compare(32'(err), 32'd0, $sformatf("pslverr on read of CSR %h", addr));
    endtask

    // holds irq and ret for one cycle, checks the redirect, then the new level.
    task automatic pulse_event(input logic [31:0] lines, input logic mret, input logic sret,
                               input logic [31:0] epc);
        logic        exp_insert;
        logic [31:0] exp_pc;
        @(posedge clk);
        #2;
        irq      = lines[5:0];
        ret.mret = mret;
        ret.sret = sret;
        ret.epc  = epc;
        model_event(lines[5:0], mret, sret, epc, exp_insert, exp_pc);
        @(negedge clk);
        compare(32'(insert_pc), 32'(exp_insert), "insert_pc");
        compare(priv_pc, exp_pc, "priv_pc");
        @(posedge clk);
        #2;
        irq = '0;
        ret = '0;
        @(negedge clk);
        compare(32'(priv_level), 32'(m_priv), "priv_level after event");
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] pick;
        logic        err;
        lfsr_state = 32'h1337;
        errors     = 0;
        timeouts   = 0;
        rst_n      = 1'b0;
        apb_req    = '0;
        irq        = '0;
        ret        = '0;
        {m_mtvec, m_stvec, m_mepc, m_sepc, m_mcause, m_scause} = '0;
        {m_mideleg, m_irq_en, m_mie, m_sie, m_mpie, m_spie, m_spp, m_mpp} = '0;
        m_priv = 2'b11; // the hart leaves reset in M.
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        compare(32'(priv_level), 32'd3, "priv_level after reset");
        compare(32'(insert_pc), 32'd0, "insert_pc after reset");
        compare(32'(apb_rsp.pready), 32'd0, "pready after reset");
        for (int i = 0; i < 9; i++) csr_read_check(CSR_LIST[i]);

        // random writes then reads, and the error response of an unknown CSR.
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 9; i++) csr_write(CSR_LIST[i], rand_bits(32));
            for (int i = 0; i < 9; i++) csr_read_check(CSR_LIST[i]);
        end
        apb_access(1'b0, 12'h7C0, 32'd0, rd, err);
        compare(rd, 32'd0, "prdata of unknown CSR");
        compare(32'(err), 32'd1, "pslverr of unknown CSR");
        apb_access(1'b1, 12'h7C0, rand_bits(32), rd, err);
        compare(32'(err), 32'd1, "pslverr of write to unknown CSR");

        // each round does an mret to a random level and then a random interrupt pattern.
        for (int k = 0; k < 40; k++) begin
            csr_write(priv_isa_pkg::CSR_MSTATUS, rand_bits(32));
            pulse_event(32'd0, 1'b1, 1'b0, rand_bits(32));
            csr_write(priv_isa_pkg::CSR_MSTATUS, rand_bits(32));
            csr_write(priv_isa_pkg::CSR_MIDELEG, rand_bits(6));
            csr_write(priv_isa_pkg::CSR_IRQ_ENABLE, rand_bits(6));
            csr_write(priv_isa_pkg::CSR_MTVEC, rand_bits(32));
            csr_write(priv_isa_pkg::CSR_STVEC, rand_bits(32));
            pulse_event(rand_bits(6), 1'b0, 1'b0, rand_bits(32));
            for (int i = 0; i < 9; i++) csr_read_check(CSR_LIST[i]);
        end

        // in M with all lines delegated nothing traps, in S an M line traps with MIE clear.
        csr_write(priv_isa_pkg::CSR_MSTATUS, 32'h0000_1800);
        pulse_event(32'd0, 1'b1, 1'b0, 32'h0000_1000);
        csr_write(priv_isa_pkg::CSR_MSTATUS, 32'h0000_000A);
        csr_write(priv_isa_pkg::CSR_MIDELEG, 32'h3F);
        csr_write(priv_isa_pkg::CSR_IRQ_ENABLE, 32'h3F);
        pulse_event(32'h3F, 1'b0, 1'b0, 32'h0000_2000);
        csr_write(priv_isa_pkg::CSR_MSTATUS, 32'h0000_0800);
        pulse_event(32'd0, 1'b1, 1'b0, 32'h0000_3000);
        csr_write(priv_isa_pkg::CSR_MSTATUS, 32'h0000_0000);
        csr_write(priv_isa_pkg::CSR_MIDELEG, 32'h00);
        pulse_event(32'h08, 1'b0, 1'b0, 32'h0000_4004);
        csr_read_check(priv_isa_pkg::CSR_MCAUSE);
        csr_read_check(priv_isa_pkg::CSR_MSTATUS);

        // random returns restore the level and the mstatus stack.
        for (int k = 0; k < 20; k++) begin
            csr_write(priv_isa_pkg::CSR_MEPC, rand_bits(32));
            csr_write(priv_isa_pkg::CSR_SEPC, rand_bits(32));
            csr_write(priv_isa_pkg::CSR_MSTATUS, rand_bits(32));
            pick = rand_bits(1);
            pulse_event(32'd0, pick[0], ~pick[0], rand_bits(32));
            csr_read_check(priv_isa_pkg::CSR_MSTATUS);
        end

        // when MEI and mret arrive together the trap wins and saves the mret's epc.
        csr_write(priv_isa_pkg::CSR_MIDELEG, 32'h00);
        csr_write(priv_isa_pkg::CSR_IRQ_ENABLE, 32'h3F);
        csr_write(priv_isa_pkg::CSR_MSTATUS, 32'h0000_0008);
        csr_write(priv_isa_pkg::CSR_MTVEC, rand_bits(32));
        csr_write(priv_isa_pkg::CSR_MEPC, rand_bits(32));
        pulse_event(32'h20, 1'b1, 1'b0, rand_bits(32));
        csr_read_check(priv_isa_pkg::CSR_MEPC);
        csr_read_check(priv_isa_pkg::CSR_MCAUSE);
        csr_read_check(priv_isa_pkg::CSR_MSTATUS);

        $display("run complete with %0d mismatches and %0d timeouts.", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
logic/priv_isa_pkg.sv
logic/priv_bus_pkg.sv
logic/priv_trap_ctrl.sv
logic/priv_csr_file.sv
logic/priv_pipe_control.sv
logic/priv_unit.sv
dv/priv_unit_tb.sv

// File: Makefile
# Verilator build and run of the trap unit testbench.
VERILATOR ?= verilator
TOP       ?= priv_unit_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Simulation PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# the run passes only when the pass message shows up in the output.
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
